/* design/axi_wr_pkg.sv */
// Widths and burst limits for a 32-bit AXI4 write master
// Transfer size is capped at 64 KB by size_w

package axi_wr_pkg;

  //////////////////////////////////////////////////
  // Bus and command widths
  //////////////////////////////////////////////////
  localparam int addr_w     = 32;
  localparam int data_w     = 32;
  localparam int strb_w     = data_w / 8;
  localparam int size_w     = 16;
  localparam int byte_idx_w = $clog2(strb_w);

  //////////////////////////////////////////////////
  // Burst limits
  //////////////////////////////////////////////////
  // AXI caps a burst at 256 beats and at 4 KB, whichever comes first
  localparam int max_burst_beats = (256 < 4096 / strb_w) ? 256 : 4096 / strb_w;
  localparam int beat_idx_w      = $clog2(max_burst_beats);
  // Also the start address alignment
  localparam int burst_bytes     = max_burst_beats * strb_w;
  // Beats minus one, then split into burst count and last length
  localparam int total_len_w     = size_w - byte_idx_w;
  localparam int burst_cnt_w     = total_len_w - beat_idx_w;
  localparam int max_outstanding = 32;
  localparam int vacancy_w       = $clog2(max_outstanding + 1);
  localparam int fifo_depth      = 32;
  localparam int fifo_ptr_w      = $clog2(fifo_depth);

  typedef logic [addr_w-1:0]      addr_t;
  typedef logic [data_w-1:0]      data_t;
  typedef logic [strb_w-1:0]      strb_t;
  typedef logic [beat_idx_w-1:0]  beat_cnt_t;
  typedef logic [burst_cnt_w-1:0] burst_cnt_t;
  typedef logic [vacancy_w-1:0]   vacancy_t;

endpackage

/* design/xfer_counter.sv */
// Load wins over incr/decr, simultaneous incr and decr hold the count
// Decrement from zero wraps to all ones

module xfer_counter #(
  parameter type    count_t    = logic [7:0],
  parameter count_t init_value = '0
) (
  input  logic   aclk,
  input  logic   areset,
  input  logic   load,
  input  logic   incr,
  input  logic   decr,
  input  count_t load_value,
  output count_t count,
  output logic   is_zero
);

  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= init_value;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + count_t'(1);
    end else if (decr && !incr) begin
      count <= count - count_t'(1);
    end
  end

  // Flag from the registered value
  assign is_zero = (count == '0);

endmodule

/* design/wdata_fifo.sv */
// First-word-fall-through FIFO, depth must be a power of two
// Push while full and pop while empty are dropped

module wdata_fifo (
  input  logic              aclk,
  input  logic              areset,
  input  logic              push,
  input  axi_wr_pkg::data_t push_data,
  output logic              full,
  input  logic              pop,
  output axi_wr_pkg::data_t pop_data,
  output logic              pop_valid
);

  import axi_wr_pkg::*;

  data_t                 mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;
  logic                  do_push;
  logic                  do_pop;

  assign full      = (count == fifo_depth);
  assign pop_valid = (count != '0);
  assign do_push   = push && !full;
  assign do_pop    = pop && pop_valid;

  // Head word is visible without a read strobe
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap on their own width
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // occupancy, unchanged when both happen
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* design/wr_cmd_regs.sv */
// ctrl_start must wait for ctrl_done of the previous transfer; a size of zero is not supported
// Address is rounded down to a 1 KB burst boundary

module wr_cmd_regs (
  input  logic                           aclk,
  input  logic                           areset,
  input  logic                           ctrl_start,
  input  axi_wr_pkg::addr_t              ctrl_addr_offset,
  input  logic [axi_wr_pkg::size_w-1:0]  ctrl_xfer_size_in_bytes,
  output logic                           start,
  output axi_wr_pkg::addr_t              base_addr,
  output axi_wr_pkg::burst_cnt_t         num_bursts,
  output axi_wr_pkg::beat_cnt_t          last_len,
  output logic                           single_burst,
  output axi_wr_pkg::strb_t              final_strb
);

  import axi_wr_pkg::*;

  logic                   start_d1;
  logic [byte_idx_w-1:0]  byte_rem;
  logic [total_len_w-1:0] total_len_r;

  // Bytes in the final beat, zero means a full beat
  assign byte_rem = ctrl_xfer_size_in_bytes[byte_idx_w-1:0];

  // Two-stage start delay gives the derived fields time to settle
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      start    <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      start    <= start_d1;
    end
  end

  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Beats minus one, rounded up to whole beats
      total_len_r <= (byte_rem != '0)
                     ? ctrl_xfer_size_in_bytes[byte_idx_w +: total_len_w]
                     : ctrl_xfer_size_in_bytes[byte_idx_w +: total_len_w] - 1'b1;
      base_addr   <= ctrl_addr_offset & ~addr_t'(burst_bytes - 1);
      // Low bytes only on a partial last beat
      final_strb  <= (byte_rem == '0) ? '1 : strb_t'((1 << byte_rem) - 1);
    end
  end

  // Upper bits count full bursts after the first
  assign num_bursts   = total_len_r[beat_idx_w +: burst_cnt_w];
  // Lower bits are the awlen of the last burst
  assign last_len     = total_len_r[beat_idx_w-1:0];
  assign single_burst = (num_bursts == '0);

endmodule

/* design/w_channel.sv */
// W beats flow only while running, i.e. between start and the final beat
// Every strobe is full except on the final beat of the transfer

module w_channel (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   start,
  input  axi_wr_pkg::burst_cnt_t num_bursts,
  input  axi_wr_pkg::beat_cnt_t  last_len,
  input  logic                   single_burst,
  input  axi_wr_pkg::strb_t      final_strb,
  input  logic                   fifo_valid,
  input  axi_wr_pkg::data_t      fifo_data,
  output logic                   fifo_pop,
  output logic                   m_axi_wvalid,
  input  logic                   m_axi_wready,
  output axi_wr_pkg::data_t      m_axi_wdata,
  output axi_wr_pkg::strb_t      m_axi_wstrb,
  output logic                   m_axi_wlast,
  output logic                   first_beat_pulse
);

  import axi_wr_pkg::*;

  logic       running;
  logic       wxfer;
  logic       final_burst;
  logic       final_xfer;
  logic       load_beats;
  logic       wfirst;
  logic       wfirst_d1;
  burst_cnt_t bursts_to_go;

  //////////////////////////////////////////////////
  // Data path gated by running
  //////////////////////////////////////////////////
  assign m_axi_wvalid = fifo_valid && running;
  assign m_axi_wdata  = fifo_data;
  assign fifo_pop     = m_axi_wready && running;
  assign wxfer        = m_axi_wvalid && m_axi_wready;
  assign final_xfer   = wxfer && m_axi_wlast && final_burst;
  assign m_axi_wstrb  = (m_axi_wlast && final_burst) ? final_strb : '1;

  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
    end else if (final_xfer) begin
      running <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Beat and burst counters
  //////////////////////////////////////////////////
  // Short burst is loaded as the second-to-last burst closes
  assign load_beats = (wxfer && m_axi_wlast && (bursts_to_go == burst_cnt_t'(1)))
                   || (start && single_burst);

  // Full bursts wrap from zero back to 255
  xfer_counter #(.count_t(beat_cnt_t), .init_value('1)) i_beat_cnt (
    .aclk, .areset, .load(load_beats), .incr(1'b0), .decr(wxfer),
    .load_value(last_len), .count(), .is_zero(m_axi_wlast)
  );

  xfer_counter #(.count_t(burst_cnt_t), .init_value('0)) i_burst_cnt (
    .aclk, .areset, .load(start), .incr(1'b0), .decr(wxfer && m_axi_wlast),
    .load_value(num_bursts), .count(bursts_to_go), .is_zero(final_burst)
  );

  // First-beat flag, one pulse per burst when its first beat shows on W
  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst           <= 1'b1;
      wfirst_d1        <= 1'b0;
      first_beat_pulse <= 1'b0;
    end else begin
      if (wxfer) begin
        wfirst <= m_axi_wlast;
      end
      wfirst_d1        <= m_axi_wvalid && wfirst;
      first_beat_pulse <= m_axi_wvalid && wfirst && !wfirst_d1;
    end
  end

endmodule

/* design/aw_channel.sv */
// An address goes out only after its burst's first W beat was seen
// Bursts advance by 1 KB from the aligned base address

module aw_channel (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   start,
  input  axi_wr_pkg::addr_t      base_addr,
  input  axi_wr_pkg::burst_cnt_t num_bursts,
  input  axi_wr_pkg::beat_cnt_t  last_len,
  input  logic                   single_burst,
  input  logic                   first_beat_pulse,
  input  logic                   stall_aw,
  output logic                   m_axi_awvalid,
  input  logic                   m_axi_awready,
  output axi_wr_pkg::addr_t      m_axi_awaddr,
  output axi_wr_pkg::beat_cnt_t  m_axi_awlen,
  output logic                   aw_xfer
);

  import axi_wr_pkg::*;

  logic idle_aw;
  logic final_aw;

  assign aw_xfer = m_axi_awvalid && m_axi_awready;

  // Bursts with data on the way but no address yet
  xfer_counter #(.count_t(beat_cnt_t), .init_value('0)) i_pending_cnt (
    .aclk, .areset, .load(1'b0), .incr(first_beat_pulse), .decr(aw_xfer),
    .load_value('0), .count(), .is_zero(idle_aw)
  );

  // Address bursts left, zero on the final one
  xfer_counter #(.count_t(burst_cnt_t), .init_value('0)) i_aw_burst_cnt (
    .aclk, .areset, .load(start), .incr(1'b0), .decr(aw_xfer),
    .load_value(num_bursts), .count(), .is_zero(final_aw)
  );

  //////////////////////////////////////////////////
  // Valid, address and length
  //////////////////////////////////////////////////
  // Raise from idle only, then hold until accepted
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_awvalid <= 1'b0;
    end else if (!m_axi_awvalid) begin
      m_axi_awvalid <= !idle_aw && !stall_aw;
    end else if (m_axi_awready) begin
      m_axi_awvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (start) begin
      m_axi_awaddr <= base_addr;
    end else if (aw_xfer) begin
      m_axi_awaddr <= m_axi_awaddr + addr_t'(burst_bytes);
    end
  end

  // Short length only on the last burst
  assign m_axi_awlen = (final_aw || (start && single_burst))
                       ? last_len : beat_cnt_t'(max_burst_beats - 1);

endmodule

/* design/b_channel.sv */
// bready is tied high at the top, so every bvalid is a response
// At most max_outstanding addresses wait for a response

module b_channel (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   start,
  input  axi_wr_pkg::burst_cnt_t num_bursts,
  input  logic                   aw_xfer,
  input  logic                   m_axi_bvalid,
  output logic                   stall_aw,
  output logic                   ctrl_done
);

  import axi_wr_pkg::*;

  logic final_b;

  // Responses left in this transfer
  xfer_counter #(.count_t(burst_cnt_t), .init_value('0)) i_b_burst_cnt (
    .aclk, .areset, .load(start), .incr(1'b0), .decr(m_axi_bvalid),
    .load_value(num_bursts), .count(), .is_zero(final_b)
  );

  // Free outstanding slots, empty means stall
  xfer_counter #(.count_t(vacancy_t), .init_value(vacancy_t'(max_outstanding))) i_vacancy (
    .aclk, .areset, .load(1'b0), .incr(m_axi_bvalid), .decr(aw_xfer),
    .load_value('0), .count(), .is_zero(stall_aw)
  );

  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= m_axi_bvalid && final_b;
    end
  end

endmodule

/* design/axi_write_master.sv */
// Stream-to-memory AXI4 write master, single clock domain
// Start one transfer at a time and wait for ctrl_done before the next

module axi_write_master (
  input  logic                           aclk,
  input  logic                           areset,
  input  logic                           ctrl_start,
  input  axi_wr_pkg::addr_t              ctrl_addr_offset,
  input  logic [axi_wr_pkg::size_w-1:0]  ctrl_xfer_size_in_bytes,
  output logic                           ctrl_done,
  input  logic                           s_axis_tvalid,
  output logic                           s_axis_tready,
  input  axi_wr_pkg::data_t              s_axis_tdata,
  output logic                           m_axi_awvalid,
  input  logic                           m_axi_awready,
  output axi_wr_pkg::addr_t              m_axi_awaddr,
  output axi_wr_pkg::beat_cnt_t          m_axi_awlen,
  output logic                           m_axi_wvalid,
  input  logic                           m_axi_wready,
  output axi_wr_pkg::data_t              m_axi_wdata,
  output axi_wr_pkg::strb_t              m_axi_wstrb,
  output logic                           m_axi_wlast,
  input  logic                           m_axi_bvalid,
  output logic                           m_axi_bready
);

  import axi_wr_pkg::*;

  logic       start;
  addr_t      base_addr;
  burst_cnt_t num_bursts;
  beat_cnt_t  last_len;
  logic       single_burst;
  strb_t      final_strb;
  logic       fifo_full;
  logic       fifo_valid;
  data_t      fifo_data;
  logic       fifo_pop;
  logic       first_beat_pulse;
  logic       aw_xfer;
  logic       stall_aw;

  // Responses are always taken, stream is held off only by a full FIFO
  assign m_axi_bready  = 1'b1;
  assign s_axis_tready = !fifo_full;

  wr_cmd_regs i_cmd (.*, .start(start));

  wdata_fifo i_fifo (
    .aclk, .areset, .push(s_axis_tvalid), .push_data(s_axis_tdata), .full(fifo_full),
    .pop(fifo_pop), .pop_data(fifo_data), .pop_valid(fifo_valid)
  );

  w_channel i_w (.*);

  aw_channel i_aw (.*);

  b_channel i_b (.*);

endmodule

/* verification/axi_mem_model.sv */
// AXI4 write slave with random ready, one B per burst after its AW and wlast
// bvalid holds until bready; logs hold up to 4096 beats and bursts in total

module axi_mem_model (
  input  logic                  aclk,
  input  logic                  areset,
  input  logic [31:0]           rand_bits,
  input  logic                  hold_w,
  input  logic                  awvalid,
  output logic                  awready,
  input  axi_wr_pkg::addr_t     awaddr,
  input  axi_wr_pkg::beat_cnt_t awlen,
  input  logic                  wvalid,
  output logic                  wready,
  input  axi_wr_pkg::data_t     wdata,
  input  axi_wr_pkg::strb_t     wstrb,
  input  logic                  wlast,
  output logic                  bvalid,
  input  logic                  bready
);

  timeunit 1ns;
  timeprecision 1ps;

  import axi_wr_pkg::*;

  localparam int log_depth = 4096;

  addr_t     aw_addr_log       [log_depth];
  beat_cnt_t aw_len_log        [log_depth];
  logic      aw_after_data_log [log_depth];
  data_t     w_data_log        [log_depth];
  strb_t     w_strb_log        [log_depth];
  logic      w_last_log        [log_depth];
  int        aw_count;
  int        w_count;
  int        wlast_count;
  int        b_count;
  int        first_valid_count;
  logic      first_flagged;

  always @(posedge aclk) begin
    if (areset) begin
      awready           <= 1'b0;
      wready            <= 1'b0;
      bvalid            <= 1'b0;
      aw_count          = 0;
      w_count           = 0;
      wlast_count       = 0;
      b_count           = 0;
      first_valid_count = 0;
      first_flagged     = 1'b0;
    end else begin
      // AW log, checked against first beats seen before this edge
      if (awvalid && awready && aw_count < log_depth) begin
        aw_addr_log[aw_count]       = awaddr;
        aw_len_log[aw_count]        = awlen;
        aw_after_data_log[aw_count] = (first_valid_count > aw_count);
        aw_count++;
      end
      // First beat of a burst shown on W
      if (wvalid && !first_flagged) begin
        first_valid_count++;
        first_flagged = 1'b1;
      end
      if (wvalid && wready && w_count < log_depth) begin
        w_data_log[w_count] = wdata;
        w_strb_log[w_count] = wstrb;
        w_last_log[w_count] = wlast;
        w_count++;
        if (wlast) begin
          wlast_count++;
          first_flagged = 1'b0;
        end
      end
      // A pending response holds until bready
      if (!bvalid || bready) begin
        // New response once both halves of a burst have arrived
        if (b_count < aw_count && b_count < wlast_count && rand_bits[24]) begin
          bvalid <= 1'b1;
          b_count++;
        end else begin
          bvalid <= 1'b0;
        end
      end
      awready <= rand_bits[20] | rand_bits[21];
      wready  <= !hold_w && (rand_bits[22] | rand_bits[23]);
    end
  end

endmodule

/* verification/tb_axi_write_master.sv */
// Runs a table of transfers through the write master and checks the bus logs
// Stops at the first mismatch or timeout

module tb_axi_write_master;

  timeunit 1ns;
  timeprecision 1ps;

  import axi_wr_pkg::*;

  typedef struct packed {
    logic [31:0] offset;
    logic [15:0] size;
    logic [7:0]  bursts;
    logic [7:0]  last_len;
    logic        stall_w;
  } row_t;

  localparam int num_rows = 6;

  // Offset, size in bytes, AW count, last awlen, long wready stalls
  localparam row_t test_rows [num_rows] = '{
    '{32'h0000_1000, 16'd4,    8'd1, 8'd0,   1'b0},
    '{32'h0000_2345, 16'd1023, 8'd1, 8'd255, 1'b0},
    '{32'h1000_0010, 16'd1030, 8'd2, 8'd1,   1'b1},
    '{32'h0003_03FF, 16'd3073, 8'd4, 8'd0,   1'b0},
    '{32'h0000_0400, 16'd2048, 8'd2, 8'd255, 1'b1},
    '{32'h8000_0002, 16'd5,    8'd1, 8'd1,   1'b0}
  };

  logic              aclk;
  logic              areset;
  logic              ctrl_start;
  addr_t             ctrl_addr_offset;
  logic [size_w-1:0] ctrl_xfer_size_in_bytes;
  logic              ctrl_done;
  logic              s_axis_tvalid;
  logic              s_axis_tready;
  data_t             s_axis_tdata;
  logic              m_axi_awvalid;
  logic              m_axi_awready;
  addr_t             m_axi_awaddr;
  beat_cnt_t         m_axi_awlen;
  logic              m_axi_wvalid;
  logic              m_axi_wready;
  data_t             m_axi_wdata;
  strb_t             m_axi_wstrb;
  logic              m_axi_wlast;
  logic              m_axi_bvalid;
  logic              m_axi_bready;
  logic              hold_w;
  logic              bp_mode;
  logic [31:0]       bus_state;
  logic [31:0]       stream_state;
  logic [31:0]       cycle_cnt;
  int                done_count;
  int                tready_low_count;
  data_t             exp_words [$];

  axi_write_master i_dut (.*);

  axi_mem_model i_mem (
    .aclk, .areset, .rand_bits(bus_state), .hold_w,
    .awvalid(m_axi_awvalid), .awready(m_axi_awready), .awaddr(m_axi_awaddr),
    .awlen(m_axi_awlen), .wvalid(m_axi_wvalid), .wready(m_axi_wready),
    .wdata(m_axi_wdata), .wstrb(m_axi_wstrb), .wlast(m_axi_wlast),
    .bvalid(m_axi_bvalid), .bready(m_axi_bready)
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  //////////////////////////////////////////////////
  // Failure reporting
  //////////////////////////////////////////////////
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Fail %s: got 0x%0h, expected 0x%0h",
                                  name, actual, expected));
    end
  endtask

  // Counters and bus randomness, all updated with NBAs
  always @(posedge aclk) begin
    bus_state <= lcg_step(bus_state);
    cycle_cnt <= cycle_cnt + 1;
    // Stall wready for 96 of every 128 cycles
    hold_w    <= bp_mode && (cycle_cnt[6:5] != 2'b00);
    if (ctrl_done) begin
      done_count <= done_count + 1;
    end
    if (!s_axis_tready) begin
      tready_low_count <= tready_low_count + 1;
    end
  end

  //////////////////////////////////////////////////
  // Stream driver and waits
  //////////////////////////////////////////////////
  task automatic stream_beats(input int beats);
    int sent;
    int shown;
    int idle;
    sent  = 0;
    shown = 0;
    idle  = 0;
    while (sent < beats) begin
      @(posedge aclk);
      if (s_axis_tvalid && s_axis_tready) begin
        sent++;
        idle = 0;
      end else begin
        idle++;
        if (idle > 1000) begin
          stop_with_failure("Timeout: a stream beat waited 1000 cycles for tready");
        end
      end
      // Beat holds until accepted, random gaps otherwise
      if (!s_axis_tvalid || s_axis_tready) begin
        stream_state = lcg_step(stream_state);
        if (shown < beats && stream_state[29:28] != 2'b00) begin
          s_axis_tvalid <= 1'b1;
          s_axis_tdata  <= stream_state;
          exp_words.push_back(stream_state);
          shown++;
        end else begin
          s_axis_tvalid <= 1'b0;
        end
      end
    end
  endtask

  task automatic wait_for_done();
    int waited;
    waited = 0;
    do begin
      @(posedge aclk);
      waited++;
      if (waited > 10000) begin
        stop_with_failure("Timeout: ctrl_done did not pulse within 10000 cycles");
      end
    end while (!ctrl_done);
  endtask

  task automatic run_row(input int r);
    row_t  row;
    int    beats;
    int    aw_base;
    int    w_base;
    int    low_base;
    int    k;
    addr_t exp_addr;
    strb_t last_strb;
    row      = test_rows[r];
    beats    = (row.size + 3) / 4;
    // Bus is idle between rows so the log counts are stable
    aw_base  = i_mem.aw_count;
    w_base   = i_mem.w_count;
    low_base = tready_low_count;
    exp_words.delete();
    bp_mode                 <= row.stall_w;
    ctrl_start              <= 1'b1;
    ctrl_addr_offset        <= row.offset;
    ctrl_xfer_size_in_bytes <= row.size;
    @(posedge aclk);
    ctrl_start <= 1'b0;
    stream_beats(beats);
    wait_for_done();
    // Done follows the final response
    check_value("bvalid count", i_mem.b_count, i_mem.aw_count);
    check_value("m_axi_wvalid beat count", i_mem.w_count - w_base, beats);
    bp_mode <= 1'b0;
    repeat (2) @(posedge aclk);
    check_value("ctrl_done pulse count", done_count, r + 1);
    // Burst split and address alignment
    check_value("m_axi_awvalid burst count", i_mem.aw_count - aw_base, row.bursts);
    exp_addr = row.offset & ~32'h3FF;
    for (k = 0; k < row.bursts; k++) begin
      check_value("m_axi_awaddr", i_mem.aw_addr_log[aw_base + k], exp_addr);
      check_value("m_axi_awlen", i_mem.aw_len_log[aw_base + k],
                  (k == row.bursts - 1) ? row.last_len : 8'd255);
      check_value("AW after first W beat", i_mem.aw_after_data_log[aw_base + k], 1);
      exp_addr = exp_addr + 32'd1024;
    end
    // Valid bytes in the final beat
    case (row.size % 4)
      1: last_strb = 4'h1;
      2: last_strb = 4'h3;
      3: last_strb = 4'h7;
      default: last_strb = 4'hF;
    endcase
    // Data order, wlast and strobes
    for (k = 0; k < beats; k++) begin
      check_value("m_axi_wdata", i_mem.w_data_log[w_base + k], exp_words[k]);
      check_value("m_axi_wstrb", i_mem.w_strb_log[w_base + k],
                  (k == beats - 1) ? last_strb : 4'hF);
      check_value("m_axi_wlast", i_mem.w_last_log[w_base + k],
                  (k % 256 == 255) || (k == beats - 1));
    end
    if (row.stall_w) begin
      check_value("s_axis_tready dropped", (tready_low_count - low_base) > 0, 1);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    s_axis_tvalid           = 1'b0;
    s_axis_tdata            = '0;
    bp_mode                 = 1'b0;
    hold_w                  = 1'b0;
    cycle_cnt               = '0;
    done_count              = 0;
    tready_low_count        = 0;
    stream_state            = 32'd1660;
    bus_state               = lcg_step(32'd1660);
    repeat (3) @(posedge aclk);
    areset <= 1'b0;
    @(posedge aclk);
    check_value("m_axi_bready", m_axi_bready, 1);
    check_value("m_axi_awvalid after reset", m_axi_awvalid, 0);
    check_value("m_axi_wvalid after reset", m_axi_wvalid, 0);
    check_value("ctrl_done after reset", ctrl_done, 0);
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    // No stray done pulse after the last transfer
    repeat (20) @(posedge aclk);
    check_value("ctrl_done pulse count", done_count, num_rows);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* axi_write_master.f */
design/axi_wr_pkg.sv
design/xfer_counter.sv
design/wdata_fifo.sv
design/wr_cmd_regs.sv
design/w_channel.sv
design/aw_channel.sv
design/b_channel.sv
design/axi_write_master.sv
verification/axi_mem_model.sv
verification/tb_axi_write_master.sv
